// ==== Bender.yml ====
package:
  name: mem_wb_pipe

sources:
  - src/mem_definitions.sv
  - src/pipe_definitions.sv
  - src/ex_m_buffer.sv
  - src/mem_access.sv
  - src/dmem_arbiter.sv
  - src/data_mem.sv
  - src/m_wb_stage.sv
  - src/mem_wb_top.sv
  - target: test
    files:
      - bench/tb_mem_wb_top.sv

// ==== bench/mem_wb_stim.txt ====
# P ctrl mask rs2 rd alu_out mem_data sext_out pc_inc rand stall flush exp_we exp_rd exp_data
# ctrl={MemToReg,RegWrite,MemWrite,MemRead,JAL,LUI} rand=data fields redrawn | W/R addr data err | I
P 10 2 00 01 12345678 0 0 0 e 0 0 1 01 12345678
P 12 2 00 02 0 0 0 00000104 7 0 0 1 02 00000104
P 11 2 00 03 0 0 abcde000 0 b 0 0 1 03 abcde000
P 08 2 00 00 00000100 8899aabb 0 0 c 0 0 0 00 0
P 08 0 00 00 00000101 000000cc 0 0 c 0 0 0 00 0
P 08 1 00 00 00000102 00007e5a 0 0 c 0 0 0 00 0
P 34 0 00 04 00000101 0 0 0 e 0 0 1 04 ffffffcc
P 34 3 00 05 00000101 0 0 0 e 0 0 1 05 000000cc
P 34 1 00 06 00000100 0 0 0 e 0 0 1 06 ffffccbb
P 34 4 00 07 00000102 0 0 0 e 0 0 1 07 00007e5a
P 34 2 00 08 00000100 0 0 0 e 0 0 1 08 7e5accbb
P 10 2 00 0b deadbeef 0 0 0 e 0 0 1 0b deadbeef
P 08 2 0b 00 00000108 11111111 0 0 c 0 0 0 00 0
P 34 2 00 0c 00000108 0 0 0 e 0 0 1 0c deadbeef
P 08 2 00 00 00000108 00000000 0 0 c 0 1 0 00 0
P 10 2 00 0d 0 0 0 0 f 0 1 0 00 0
P 34 2 00 0e 00000108 0 0 0 e 0 0 1 0e deadbeef
P 10 2 00 0f 0000a0a0 0 0 0 e 0 0 1 0f 0000a0a0
P 00 2 00 00 0 0 0 0 f 1 0 0 00 0
P 10 2 00 10 0000b0b0 0 0 0 e 0 0 1 10 0000b0b0
W 200 cafef00d 0
I
I
I
P 34 2 00 11 00000200 0 0 0 e 0 0 1 11 cafef00d
P 08 2 00 00 00000204 13572468 0 0 c 0 0 0 00 0
I
I
R 204 13572468 0
W 400 00000000 1
R 100 7e5accbb 0
P 08 2 00 00 0000010c 55aa55aa 0 0 c 0 0 0 00 0
P 34 2 00 12 0000010c 0 0 0 e 0 0 1 12 55aa55aa
P 08 1 00 00 0000010e 0000abcd 0 0 c 0 0 0 00 0
P 34 4 00 13 0000010e 0 0 0 e 0 0 1 13 0000abcd
P 34 0 00 14 00000101 0 0 0 e 0 0 1 14 ffffffcc

// ==== bench/tb_mem_wb_top.sv ====
`default_nettype none

module tb_mem_wb_top;

    localparam int MAX_REC = 64;
    localparam int N_FIELD = 14;
    localparam int PERIOD  = 40;

    logic                                 clk;
    logic                                 rst_n;
    logic                                 stall;
    logic                                 flush;
    logic                                 ex_MemToReg, ex_RegWrite, ex_MemWrite, ex_MemRead;
    logic                                 ex_JAL, ex_LUI;
    mem_definitions::mem_mask_t           ex_Mmask;
    logic [pipe_definitions::REG_AW-1:0]  ex_rs2, ex_rd;
    logic [pipe_definitions::XLEN-1:0]    ex_alu_out, ex_mem_data, ex_sext_out, ex_pc_inc_out;
    logic [mem_definitions::PADDR_W-1:0]  paddr;
    logic                                 psel, penable, pwrite, pready, pslverr;
    logic [pipe_definitions::XLEN-1:0]    pwdata, prdata;
    logic                                 wb_reg_write;
    logic [pipe_definitions::REG_AW-1:0]  wb_rd;
    logic [pipe_definitions::XLEN-1:0]    wb_data;

    byte         rec_kind [MAX_REC];
    logic [31:0] rec_f    [MAX_REC][N_FIELD];
    int          n_rec;
    logic        loaded;
    int          exp_cnt  [$];   // Edges left before the result shows
    logic        exp_we   [$];
    logic [4:0]  exp_rd   [$];
    logic [31:0] exp_data [$];
    logic        last_stall;
    logic        held_we;
    logic [4:0]  held_rd;
    logic [31:0] held_data;
    logic        apb_busy;
    int          apb_idx;
    int          errors;
    integer      seed;

    mem_wb_top u_dut (
        .clk, .rst_n, .stall, .flush,
        .ex_MemToReg, .ex_RegWrite, .ex_MemWrite, .ex_MemRead, .ex_JAL, .ex_LUI,
        .ex_Mmask, .ex_rs2, .ex_rd,
        .ex_alu_out, .ex_mem_data, .ex_sext_out, .ex_pc_inc_out,
        .paddr, .psel, .penable, .pwrite, .pwdata, .pready, .pslverr, .prdata,
        .wb_reg_write, .wb_rd, .wb_data
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // ======================================================================
    // Checking
    // ======================================================================
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic sample_results();
        logic        we;
        logic [4:0]  rd;
        logic [31:0] data;
        if (last_stall) begin   // Pipeline frozen
            check_value("wb_reg_write on stall", wb_reg_write, held_we);
            check_value("wb_rd on stall", wb_rd, held_rd);
            check_value("wb_data on stall", wb_data, held_data);
        end else begin
            foreach (exp_cnt[i]) begin
                exp_cnt[i] = exp_cnt[i] - 1;
            end
        end
        while (exp_cnt.size() > 0 && exp_cnt[0] == 0) begin
            void'(exp_cnt.pop_front());
            we   = exp_we.pop_front();
            rd   = exp_rd.pop_front();
            data = exp_data.pop_front();
            check_value("wb_reg_write", wb_reg_write, we);
            if (we) begin
                check_value("wb_rd", wb_rd, rd);
                check_value($sformatf("wb_data of x%0d", rd), wb_data, data);
            end
        end
        held_we   = wb_reg_write;
        held_rd   = wb_rd;
        held_data = wb_data;
    endtask

    // ======================================================================
    // Stimulus
    // ======================================================================
    task automatic load_records();
        int          fd;
        int          got;
        string       line;
        byte         kind;
        logic [31:0] v [N_FIELD];
        n_rec = 0;
        fd = $fopen("bench/mem_wb_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open the stimulus file bench/mem_wb_stim.txt");
        end else begin
            while ($fgets(line, fd) > 0) begin
                kind = line.getc(0);
                foreach (v[k]) begin
                    v[k] = '0;
                end
                got = 1;
                if (kind == "P") begin
                    got = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                  kind, v[0], v[1], v[2], v[3], v[4], v[5], v[6],
                                  v[7], v[8], v[9], v[10], v[11], v[12], v[13]) - 14;
                end else if (kind == "W" || kind == "R") begin
                    got = $sscanf(line, "%c %h %h %h", kind, v[0], v[1], v[2]) - 3;
                end
                if (got != 1) begin
                    errors++;
                    $display("Stimulus record %0d has missing fields", n_rec);
                end
                if (kind == "P" || kind == "W" || kind == "R" || kind == "I") begin
                    rec_kind[n_rec] = kind;
                    for (int k = 0; k < N_FIELD; k++) begin
                        rec_f[n_rec][k] = v[k];
                    end
                    n_rec++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic push_expect(input logic we, input logic [4:0] rd, input logic [31:0] data);
        exp_cnt.push_back(2);   // Into M, then into WB
        exp_we.push_back(we);
        exp_rd.push_back(rd);
        exp_data.push_back(data);
    endtask

    // One pipeline slot, r < 0 gives a bubble
    task automatic run_cycle(input int r);
        logic [3:0] dc;
        @(posedge clk);
        #1;
        sample_results();
        #4;
        if (r < 0) begin
            {ex_MemToReg, ex_RegWrite, ex_MemWrite, ex_MemRead, ex_JAL, ex_LUI} = 6'b0;
            stall = 1'b0;
            flush = 1'b0;
            push_expect(1'b0, 5'd0, 32'd0);
        end else begin
            dc = rec_f[r][8][3:0];
            {ex_MemToReg, ex_RegWrite, ex_MemWrite, ex_MemRead, ex_JAL, ex_LUI} = rec_f[r][0][5:0];
            ex_Mmask      = mem_definitions::mem_mask_t'(rec_f[r][1][2:0]);
            ex_rs2        = rec_f[r][2][4:0];
            ex_rd         = rec_f[r][3][4:0];
            ex_alu_out    = dc[0] ? $random(seed) : rec_f[r][4];
            ex_mem_data   = dc[1] ? $random(seed) : rec_f[r][5];
            ex_sext_out   = dc[2] ? $random(seed) : rec_f[r][6];
            ex_pc_inc_out = dc[3] ? $random(seed) : rec_f[r][7];
            stall         = rec_f[r][9][0];
            flush         = rec_f[r][10][0];
            if (!stall) begin   // A stalled slot carries no instruction
                push_expect(rec_f[r][11][0], rec_f[r][12][4:0], rec_f[r][13]);
            end
        end
        last_stall = stall;
    endtask

    task automatic apb_transfer(input int r);
        logic wr;
        wr = (rec_kind[r] == "W");
        @(posedge clk);
        #5;
        psel    = 1'b1;   // Setup
        penable = 1'b0;
        pwrite  = wr;
        paddr   = rec_f[r][0][mem_definitions::PADDR_W-1:0];
        pwdata  = wr ? rec_f[r][1] : 32'd0;
        @(posedge clk);
        #5;
        penable = 1'b1;
        #25;
        if (!wr && !rec_f[r][2][0]) begin   // Read data needs a second access cycle
            check_value("pready in first read access", pready, 1'b0);
        end
        while (!pready) begin   // Memory busy with pipeline traffic
            @(posedge clk);
            #30;
        end
        check_value("pslverr", pslverr, rec_f[r][2][0]);
        if (!wr && !rec_f[r][2][0]) begin
            check_value($sformatf("prdata at %h", paddr), prdata, rec_f[r][1]);
        end
        @(posedge clk);
        #5;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    initial begin
        forever begin
            wait (apb_busy === 1'b1);
            apb_transfer(apb_idx);
            apb_busy = 1'b0;
        end
    end

    initial begin
        wait (loaded === 1'b1);
        #(PERIOD * (n_rec * 8 + 100));
        $display("Run timed out after %0d time units with %0d errors",
                 PERIOD * (n_rec * 8 + 100), errors);
        $display("Test failed");
        $finish;
    end

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        seed       = 32'h168a;
        errors     = 0;
        rst_n      = 1'b0;
        stall      = 1'b0;
        flush      = 1'b0;
        {ex_MemToReg, ex_RegWrite, ex_MemWrite, ex_MemRead, ex_JAL, ex_LUI} = 6'b0;
        ex_Mmask   = mem_definitions::MEM_WORD;
        ex_rs2     = '0;
        ex_rd      = '0;
        ex_alu_out = '0;
        ex_mem_data   = '0;
        ex_sext_out   = '0;
        ex_pc_inc_out = '0;
        paddr      = '0;
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        pwdata     = '0;
        last_stall = 1'b0;
        apb_busy   = 1'b0;
        load_records();
        loaded = 1'b1;
        repeat (3) @(posedge clk);
        #5;
        rst_n = 1'b1;
        for (int r = 0; r < n_rec; r++) begin
            if (rec_kind[r] == "P") begin
                run_cycle(r);
            end else if (rec_kind[r] == "I") begin
                run_cycle(-1);
            end else begin
                while (apb_busy) begin   // One host transfer at a time
                    run_cycle(-1);
                end
                apb_idx  = r;
                apb_busy = 1'b1;
            end
        end
        while (apb_busy) begin
            run_cycle(-1);
        end
        repeat (3) run_cycle(-1);
        $display("Run complete with %0d errors", errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
src/mem_definitions.sv
src/pipe_definitions.sv
src/ex_m_buffer.sv
src/mem_access.sv
src/dmem_arbiter.sv
src/data_mem.sv
src/m_wb_stage.sv
src/mem_wb_top.sv
bench/tb_mem_wb_top.sv

// ==== src/data_mem.sv ====
`default_nettype none

module data_mem (
    input  logic                                  clk,
    input  logic                                  ram_en,
    input  logic                                  ram_we,
    input  logic [mem_definitions::DMEM_AW-1:0]   ram_addr,
    input  logic [mem_definitions::BE_W-1:0]      ram_be,
    input  logic [pipe_definitions::XLEN-1:0]     ram_wdata,
    output logic [pipe_definitions::XLEN-1:0]     ram_rdata
);

    logic [pipe_definitions::XLEN-1:0] mem [mem_definitions::DMEM_DEPTH];

    always_ff @(posedge clk) begin
        if (ram_en) begin
            if (ram_we) begin
                for (int i = 0; i < mem_definitions::BE_W; i++) begin
                    if (ram_be[i]) begin
                        mem[ram_addr][i*8 +: 8] <= ram_wdata[i*8 +: 8];
                    end
                end
            end else begin
                ram_rdata <= mem[ram_addr];   // Held while idle
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/dmem_arbiter.sv ====
`default_nettype none

module dmem_arbiter (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  stall,

    input  logic                                  pipe_req,
    input  logic                                  pipe_we,
    input  logic [mem_definitions::DMEM_AW-1:0]   pipe_addr,
    input  logic [mem_definitions::BE_W-1:0]      pipe_be,
    input  logic [pipe_definitions::XLEN-1:0]     pipe_wdata,

    input  logic [mem_definitions::PADDR_W-1:0]   paddr,
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [pipe_definitions::XLEN-1:0]     pwdata,
    output logic                                  pready,
    output logic                                  pslverr,
    output logic [pipe_definitions::XLEN-1:0]     prdata,

    output logic                                  ram_en,
    output logic                                  ram_we,
    output logic [mem_definitions::DMEM_AW-1:0]   ram_addr,
    output logic [mem_definitions::BE_W-1:0]      ram_be,
    output logic [pipe_definitions::XLEN-1:0]     ram_wdata,
    input  logic [pipe_definitions::XLEN-1:0]     ram_rdata
);

    typedef enum logic {
        ARB_IDLE,
        ARB_READ_DATA
    } arb_state_t;

    arb_state_t state;
    logic       access;
    logic       host_ok;
    logic       bad_addr;
    logic       host_grant;

    // ======================================================================
    // Host slot and grant
    // ======================================================================
    assign access     = psel && penable;
    assign host_ok    = !stall && !pipe_req;   // Pipeline always wins
    assign bad_addr   = |paddr[mem_definitions::PADDR_W-1:mem_definitions::BYTE_AW];
    assign host_grant = (state == ARB_IDLE) && access && !bad_addr && host_ok;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            state <= ARB_IDLE;
        end else if (state == ARB_READ_DATA) begin
            state <= ARB_IDLE;
        end else if (host_grant && !pwrite) begin
            state <= ARB_READ_DATA;   // RAM data arrives next cycle
        end
    end

    // ======================================================================
    // Memory port mux and APB response
    // ======================================================================
    assign ram_en    = pipe_req || host_grant;
    assign ram_we    = pipe_req ? pipe_we    : pwrite;
    assign ram_addr  = pipe_req ? pipe_addr  : paddr[mem_definitions::BYTE_AW-1:2];
    assign ram_be    = pipe_req ? pipe_be    : {mem_definitions::BE_W{1'b1}};
    assign ram_wdata = pipe_req ? pipe_wdata : pwdata;

    assign pready  = (state == ARB_READ_DATA)
                   || ((state == ARB_IDLE) && access && (bad_addr || (pwrite && host_ok)));
    assign pslverr = (state == ARB_IDLE) && access && bad_addr;
    assign prdata  = (state == ARB_READ_DATA) ? ram_rdata : '0;

endmodule

`default_nettype wire

// ==== src/ex_m_buffer.sv ====
`default_nettype none

module ex_m_buffer (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  stall,
    input  logic                                  flush,   // Turn slot into a bubble

    input  logic                                  ex_MemToReg,
    input  logic                                  ex_RegWrite,
    input  logic                                  ex_MemWrite,
    input  logic                                  ex_MemRead,
    input  logic                                  ex_JAL,
    input  logic                                  ex_LUI,
    input  mem_definitions::mem_mask_t            ex_Mmask,
    input  logic [pipe_definitions::REG_AW-1:0]   ex_rs2,
    input  logic [pipe_definitions::REG_AW-1:0]   ex_rd,
    input  logic [pipe_definitions::XLEN-1:0]     ex_alu_out,
    input  logic [pipe_definitions::XLEN-1:0]     ex_mem_data,
    input  logic [pipe_definitions::XLEN-1:0]     ex_sext_out,
    input  logic [pipe_definitions::XLEN-1:0]     ex_pc_inc_out,

    output logic                                  m_MemToReg,
    output logic                                  m_RegWrite,
    output logic                                  m_MemWrite,
    output logic                                  m_MemRead,
    output logic                                  m_JAL,
    output logic                                  m_LUI,
    output mem_definitions::mem_mask_t            m_Mmask,
    output logic [pipe_definitions::REG_AW-1:0]   m_rs2,
    output logic [pipe_definitions::REG_AW-1:0]   m_rd,
    output logic [pipe_definitions::XLEN-1:0]     m_alu_out,
    output logic [pipe_definitions::XLEN-1:0]     m_mem_data,
    output logic [pipe_definitions::XLEN-1:0]     m_sext_out,
    output logic [pipe_definitions::XLEN-1:0]     m_pc_inc_out
);

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            m_MemToReg   <= 1'b0;
            m_RegWrite   <= 1'b0;
            m_MemWrite   <= 1'b0;
            m_MemRead    <= 1'b0;
            m_JAL        <= 1'b0;
            m_LUI        <= 1'b0;
            m_rs2        <= '0;
            m_rd         <= '0;
            m_Mmask      <= mem_definitions::MEM_WORD;
            m_alu_out    <= '0;
            m_mem_data   <= '0;
            m_sext_out   <= '0;
            m_pc_inc_out <= '0;
        end else if (!stall) begin
            if (flush) begin   // Data and mask left as they were
                m_MemToReg <= 1'b0;
                m_RegWrite <= 1'b0;
                m_MemWrite <= 1'b0;
                m_MemRead  <= 1'b0;
                m_JAL      <= 1'b0;
                m_LUI      <= 1'b0;
                m_rs2      <= '0;
                m_rd       <= '0;
            end else begin
                m_MemToReg   <= ex_MemToReg;
                m_RegWrite   <= ex_RegWrite;
                m_MemWrite   <= ex_MemWrite;
                m_MemRead    <= ex_MemRead;
                m_JAL        <= ex_JAL;
                m_LUI        <= ex_LUI;
                m_rs2        <= ex_rs2;
                m_rd         <= ex_rd;
                m_Mmask      <= ex_Mmask;
                m_alu_out    <= ex_alu_out;
                m_mem_data   <= ex_mem_data;
                m_sext_out   <= ex_sext_out;
                m_pc_inc_out <= ex_pc_inc_out;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/m_wb_stage.sv ====
`default_nettype none

module m_wb_stage (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  stall,

    input  logic                                  m_MemToReg,
    input  logic                                  m_RegWrite,
    input  logic                                  m_JAL,
    input  logic                                  m_LUI,
    input  mem_definitions::mem_mask_t            m_Mmask,
    input  logic [pipe_definitions::REG_AW-1:0]   m_rd,
    input  logic [pipe_definitions::XLEN-1:0]     m_alu_out,
    input  logic [pipe_definitions::XLEN-1:0]     m_sext_out,
    input  logic [pipe_definitions::XLEN-1:0]     m_pc_inc_out,
    input  logic [pipe_definitions::XLEN-1:0]     ram_rdata,

    output logic                                  wb_reg_write,
    output logic [pipe_definitions::REG_AW-1:0]   wb_rd,
    output logic [pipe_definitions::XLEN-1:0]     wb_data
);

    pipe_definitions::wb_src_t           wb_src;
    mem_definitions::mem_mask_t          wb_mask;
    logic [1:0]                          wb_lane;
    logic [pipe_definitions::XLEN-1:0]   wb_alu;
    logic [pipe_definitions::XLEN-1:0]   wb_imm;
    logic [pipe_definitions::XLEN-1:0]   wb_pc_inc;
    logic [pipe_definitions::XLEN-1:0]   load_val;
    logic [7:0]                          ld_byte;
    logic [15:0]                         ld_half;

    always_ff @(posedge clk, negedge rst_n) begin
        if (!rst_n) begin
            wb_reg_write <= 1'b0;
            wb_rd        <= '0;
            wb_src       <= pipe_definitions::WB_ALU;
            wb_mask      <= mem_definitions::MEM_WORD;
            wb_lane      <= '0;
            wb_alu       <= '0;
            wb_imm       <= '0;
            wb_pc_inc    <= '0;
        end else if (!stall) begin
            wb_reg_write <= m_RegWrite;
            wb_rd        <= m_rd;
            if (m_JAL)           wb_src <= pipe_definitions::WB_PC_INC;
            else if (m_LUI)      wb_src <= pipe_definitions::WB_IMM;
            else if (m_MemToReg) wb_src <= pipe_definitions::WB_MEM;
            else                 wb_src <= pipe_definitions::WB_ALU;
            wb_mask      <= m_Mmask;
            wb_lane      <= m_alu_out[1:0];
            wb_alu       <= m_alu_out;
            wb_imm       <= m_sext_out;
            wb_pc_inc    <= m_pc_inc_out;
        end
    end

    // Lane pick from the registered RAM word
    assign ld_byte = ram_rdata[{wb_lane, 3'b000} +: 8];
    assign ld_half = ram_rdata[{wb_lane[1], 4'b0000} +: 16];

    always_comb begin
        case (wb_mask)
            mem_definitions::MEM_BYTE:   load_val = {{24{ld_byte[7]}}, ld_byte};
            mem_definitions::MEM_BYTE_U: load_val = {24'b0, ld_byte};
            mem_definitions::MEM_HALF:   load_val = {{16{ld_half[15]}}, ld_half};
            mem_definitions::MEM_HALF_U: load_val = {16'b0, ld_half};
            default:                     load_val = ram_rdata;
        endcase
    end

    always_comb begin
        case (wb_src)
            pipe_definitions::WB_MEM:    wb_data = load_val;
            pipe_definitions::WB_PC_INC: wb_data = wb_pc_inc;
            pipe_definitions::WB_IMM:    wb_data = wb_imm;
            default:                     wb_data = wb_alu;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/mem_access.sv ====
`default_nettype none

module mem_access (
    input  logic                                  m_MemWrite,
    input  logic                                  m_MemRead,
    input  mem_definitions::mem_mask_t            m_Mmask,
    input  logic [pipe_definitions::REG_AW-1:0]   m_rs2,
    input  logic [pipe_definitions::XLEN-1:0]     m_alu_out,
    input  logic [pipe_definitions::XLEN-1:0]     m_mem_data,
    input  logic                                  stall,

    input  logic                                  wb_reg_write,
    input  logic [pipe_definitions::REG_AW-1:0]   wb_rd,
    input  logic [pipe_definitions::XLEN-1:0]     wb_data,

    output logic                                  pipe_req,
    output logic                                  pipe_we,
    output logic [mem_definitions::DMEM_AW-1:0]   pipe_addr,
    output logic [mem_definitions::BE_W-1:0]      pipe_be,
    output logic [pipe_definitions::XLEN-1:0]     pipe_wdata
);

    logic                                 fwd;
    logic [1:0]                           lane;
    logic [pipe_definitions::XLEN-1:0]    store_data;

    // Store source comes from writeback when it targets rs2
    assign fwd        = wb_reg_write && (wb_rd == m_rs2) && (m_rs2 != '0);
    assign store_data = fwd ? wb_data : m_mem_data;
    assign lane       = m_alu_out[1:0];

    always_comb begin
        case (m_Mmask)
            mem_definitions::MEM_BYTE,
            mem_definitions::MEM_BYTE_U: begin
                pipe_be    = 4'b0001 << lane;
                pipe_wdata = {24'b0, store_data[7:0]} << {lane, 3'b000};
            end
            mem_definitions::MEM_HALF,
            mem_definitions::MEM_HALF_U: begin
                pipe_be    = 4'b0011 << {lane[1], 1'b0};   // Bit 0 ignored
                pipe_wdata = {16'b0, store_data[15:0]} << {lane[1], 4'b0000};
            end
            default: begin
                pipe_be    = {mem_definitions::BE_W{1'b1}};
                pipe_wdata = store_data;
            end
        endcase
    end

    assign pipe_req  = (m_MemWrite || m_MemRead) && !stall;
    assign pipe_we   = m_MemWrite;
    assign pipe_addr = m_alu_out[mem_definitions::BYTE_AW-1:2];

endmodule

`default_nettype wire

// ==== src/mem_definitions.sv ====
`default_nettype none

package mem_definitions;

    // ======================================================================
    // Access size and signedness
    // ======================================================================
    typedef enum logic [2:0] {
        MEM_BYTE,
        MEM_HALF,
        MEM_WORD,
        MEM_BYTE_U,
        MEM_HALF_U
    } mem_mask_t;

    // ======================================================================
    // Data memory geometry
    // ======================================================================
    localparam int DMEM_DEPTH = 256;   // Words
    localparam int DMEM_AW    = 8;     // Word address
    localparam int BYTE_AW    = 10;    // Byte address
    localparam int PADDR_W    = 12;    // APB address, top bits flag out of range
    localparam int BE_W       = 4;

endpackage

`default_nettype wire

// ==== src/mem_wb_top.sv ====
`default_nettype none

module mem_wb_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  stall,
    input  logic                                  flush,

    input  logic                                  ex_MemToReg,
    input  logic                                  ex_RegWrite,
    input  logic                                  ex_MemWrite,
    input  logic                                  ex_MemRead,
    input  logic                                  ex_JAL,
    input  logic                                  ex_LUI,
    input  mem_definitions::mem_mask_t            ex_Mmask,
    input  logic [pipe_definitions::REG_AW-1:0]   ex_rs2,
    input  logic [pipe_definitions::REG_AW-1:0]   ex_rd,
    input  logic [pipe_definitions::XLEN-1:0]     ex_alu_out,
    input  logic [pipe_definitions::XLEN-1:0]     ex_mem_data,
    input  logic [pipe_definitions::XLEN-1:0]     ex_sext_out,
    input  logic [pipe_definitions::XLEN-1:0]     ex_pc_inc_out,

    input  logic [mem_definitions::PADDR_W-1:0]   paddr,
    input  logic                                  psel,
    input  logic                                  penable,
    input  logic                                  pwrite,
    input  logic [pipe_definitions::XLEN-1:0]     pwdata,
    output logic                                  pready,
    output logic                                  pslverr,
    output logic [pipe_definitions::XLEN-1:0]     prdata,

    output logic                                  wb_reg_write,
    output logic [pipe_definitions::REG_AW-1:0]   wb_rd,
    output logic [pipe_definitions::XLEN-1:0]     wb_data
);

    // ======================================================================
    // Stage wires
    // ======================================================================
    logic                                 m_MemToReg, m_RegWrite, m_MemWrite, m_MemRead;
    logic                                 m_JAL, m_LUI;
    mem_definitions::mem_mask_t           m_Mmask;
    logic [pipe_definitions::REG_AW-1:0]  m_rs2, m_rd;
    logic [pipe_definitions::XLEN-1:0]    m_alu_out, m_mem_data, m_sext_out, m_pc_inc_out;

    logic                                 pipe_req, pipe_we;
    logic [mem_definitions::DMEM_AW-1:0]  pipe_addr;
    logic [mem_definitions::BE_W-1:0]     pipe_be;
    logic [pipe_definitions::XLEN-1:0]    pipe_wdata;

    logic                                 ram_en, ram_we;
    logic [mem_definitions::DMEM_AW-1:0]  ram_addr;
    logic [mem_definitions::BE_W-1:0]     ram_be;
    logic [pipe_definitions::XLEN-1:0]    ram_wdata, ram_rdata;

    ex_m_buffer u_ex_m_buffer (
        .clk, .rst_n, .stall, .flush,
        .ex_MemToReg, .ex_RegWrite, .ex_MemWrite, .ex_MemRead, .ex_JAL, .ex_LUI,
        .ex_Mmask, .ex_rs2, .ex_rd,
        .ex_alu_out, .ex_mem_data, .ex_sext_out, .ex_pc_inc_out,
        .m_MemToReg, .m_RegWrite, .m_MemWrite, .m_MemRead, .m_JAL, .m_LUI,
        .m_Mmask, .m_rs2, .m_rd,
        .m_alu_out, .m_mem_data, .m_sext_out, .m_pc_inc_out
    );

    mem_access u_mem_access (
        .m_MemWrite, .m_MemRead, .m_Mmask, .m_rs2, .m_alu_out, .m_mem_data, .stall,
        .wb_reg_write, .wb_rd, .wb_data,   // Forwarding path
        .pipe_req, .pipe_we, .pipe_addr, .pipe_be, .pipe_wdata
    );

    dmem_arbiter u_dmem_arbiter (
        .clk, .rst_n, .stall,
        .pipe_req, .pipe_we, .pipe_addr, .pipe_be, .pipe_wdata,
        .paddr, .psel, .penable, .pwrite, .pwdata, .pready, .pslverr, .prdata,
        .ram_en, .ram_we, .ram_addr, .ram_be, .ram_wdata, .ram_rdata
    );

    data_mem u_data_mem (
        .clk, .ram_en, .ram_we, .ram_addr, .ram_be, .ram_wdata, .ram_rdata
    );

    m_wb_stage u_m_wb_stage (
        .clk, .rst_n, .stall,
        .m_MemToReg, .m_RegWrite, .m_JAL, .m_LUI, .m_Mmask, .m_rd,
        .m_alu_out, .m_sext_out, .m_pc_inc_out, .ram_rdata,
        .wb_reg_write, .wb_rd, .wb_data
    );

endmodule

`default_nettype wire

// ==== src/pipe_definitions.sv ====
`default_nettype none

package pipe_definitions;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // Writeback result source
    typedef enum logic [1:0] {
        WB_ALU,
        WB_MEM,
        WB_PC_INC,
        WB_IMM
    } wb_src_t;

endpackage

`default_nettype wire
